// File: vlog.f
src/sdram_map_pkg.sv
src/sdram_bus_pkg.sv
src/frac_cen.sv
src/prom_writer.sv
src/slot_port.sv
src/slot_arbiter.sv
src/cps_mem_top.sv
bench/wb_sdram_model.sv
bench/tb_cps_mem.sv

// File: Makefile
SIM := obj_dir/tb_cps_mem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -j 0 --top-module tb_cps_mem \
		-f vlog.f -o tb_cps_mem

run: compile
	./$(SIM) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: bench/tb_cps_mem.sv
`timescale 1ns/10ps

module tb_cps_mem;

    import sdram_map_pkg::*;
    import sdram_bus_pkg::*;

    localparam logic [31:0] SEED = 32'ha92e_38e2;
    localparam int DL_MAX   = 143;
    localparam int N_READS  = 40;
    localparam int N_WRITES = 20;
    localparam int N_MULTI  = 20;
    // Clock budget per test item
    localparam int WD_CLKS  = (DL_MAX + N_READS * 3 + N_WRITES * 2 + N_MULTI * 4) * 40;

    logic                VB;
    logic                rst_n;
    logic                downloading;
    logic [sdram_aw:0]   ioctl_addr;
    logic [7:0]          ioctl_data;
    logic                ioctl_wr;
    logic                rom_cs, ram_cs, gfx_cs, snd_cs;
    logic [rom_aw-1:0]   rom_addr;
    logic [ram_aw-1:0]   ram_addr;
    logic [gfx_aw-1:0]   gfx_addr;
    logic [snd_aw-1:0]   snd_addr;
    logic                ram_we;
    logic [15:0]         ram_din;
    logic [1:0]          ram_wrmask;
    logic                rom_ok, ram_ok, gfx_ok, snd_ok;
    logic [15:0]         rom_data, ram_data;
    logic [31:0]         gfx_data;
    logic [7:0]          snd_data;
    logic                pxl_cen, cpu_cen;
    wb_req_t             sdram_wb;
    wb_rsp_t             sdram_rsp;

    logic [15:0] shadow [0:(1 << sdram_aw) - 1];
    logic [31:0] lfsr;
    int          data_errors;
    int          other_errors;

    cps_mem_top uut (
        .VB(VB), .rst_n(rst_n), .downloading(downloading), .ioctl_addr(ioctl_addr),
        .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_ok(rom_ok), .rom_data(rom_data),
        .ram_cs(ram_cs), .ram_addr(ram_addr), .ram_we(ram_we), .ram_din(ram_din),
        .ram_wrmask(ram_wrmask), .ram_ok(ram_ok), .ram_data(ram_data),
        .gfx_cs(gfx_cs), .gfx_addr(gfx_addr), .gfx_ok(gfx_ok), .gfx_data(gfx_data),
        .snd_cs(snd_cs), .snd_addr(snd_addr), .snd_ok(snd_ok), .snd_data(snd_data),
        .sdram_wb(sdram_wb), .sdram_rsp(sdram_rsp), .pxl_cen(pxl_cen), .cpu_cen(cpu_cen)
    );

    wb_sdram_model u_mem (
        .VB    ( VB        ),
        .rst_n ( rst_n     ),
        .wb    ( sdram_wb  ),
        .rsp   ( sdram_rsp )
    );

    initial begin
        VB = 1'b0;
        forever #5 VB = ~VB;
    end

    // Galois LFSR step
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic report_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        data_errors++;
        $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    // Random address for one client, repeats allowed
    task automatic pick_addr(input int client);
        logic [31:0] v;
        case (client)
            0: begin
                get_bits(6, v);
                rom_addr = rom_aw'(v);
            end
            1: begin
                get_bits(6, v);
                ram_addr = ram_aw'(v);
            end
            2: begin
                get_bits(6, v);
                gfx_addr = gfx_aw'(v);
            end
            default: begin
                get_bits(7, v);
                snd_addr = snd_aw'(v);
            end
        endcase
    endtask

    task automatic check_clients(input logic [3:0] sel);
        logic [sdram_aw-1:0] base;
        logic [15:0]         w;
        if (sel[0] && rom_data !== shadow[rom_offset + rom_addr]) begin
            report_value("rom read", rom_data, shadow[rom_offset + rom_addr]);
        end
        if (sel[1] && !ram_we && ram_data !== shadow[ram_offset + ram_addr]) begin
            report_value("ram read", ram_data, shadow[ram_offset + ram_addr]);
        end
        base = gfx_offset + {gfx_addr, 1'b0};
        if (sel[2] && gfx_data !== {shadow[base + 1'b1], shadow[base]}) begin
            report_value("gfx read", gfx_data, {shadow[base + 1'b1], shadow[base]});
        end
        w = shadow[snd_offset + (snd_addr >> 1)];
        if (sel[3] && snd_data !== (snd_addr[0] ? w[15:8] : w[7:0])) begin
            report_value("snd read", snd_data, snd_addr[0] ? w[15:8] : w[7:0]);
        end
    endtask

    // Raise cs on the chosen clients, optionally behind a download window,
    // and wait until all of them show ok
    task automatic run_access(input logic [3:0] sel, input int dl_hold);
        int cnt;
        {snd_cs, gfx_cs, ram_cs, rom_cs} = sel;
        if (dl_hold > 0) begin
            downloading = 1'b1;
            repeat (dl_hold) @(negedge VB);
            downloading = 1'b0;
        end
        cnt = 0;
        do begin
            @(negedge VB);
            cnt++;
        end while ((({snd_ok, gfx_ok, ram_ok, rom_ok} & sel) != sel) && cnt < 400);
        if (cnt >= 400) begin
            other_errors++;
            $display("Client access timed out at %0t, clients %b", $time, sel);
        end else begin
            check_clients(sel);
        end
        {snd_cs, gfx_cs, ram_cs, rom_cs} = 4'b0000;
        @(negedge VB);
    endtask

    // Enable pulse counts and ok during the download
    initial begin : monitor
        int cycles;
        int cpu_cnt;
        int pxl_cnt;
        bit started;
        cycles  = 0;
        cpu_cnt = 0;
        pxl_cnt = 0;
        started = 1'b0;
        forever begin
            @(negedge VB);
            // Past the input changes made on this edge
            #1;
            if (downloading && (rom_ok || ram_ok || gfx_ok || snd_ok)) begin
                other_errors++;
                $display("A client ok rose during the download at %0t", $time);
            end
            if (!rst_n) begin
                if (cpu_cen || pxl_cen) begin
                    report_value("cen in reset", {cpu_cen, pxl_cen}, 0);
                end
            end else if (!started) begin
                started = 1'b1;
            end else begin
                cycles++;
                cpu_cnt += cpu_cen;
                pxl_cnt += pxl_cen;
                if (cycles == 24) begin
                    if (cpu_cnt != 5) report_value("cpu_cen per 24", cpu_cnt, 5);
                    if (pxl_cnt != 4) report_value("pxl_cen per 24", pxl_cnt, 4);
                    cycles  = 0;
                    cpu_cnt = 0;
                    pxl_cnt = 0;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WD_CLKS) @(posedge VB);
        $display("Watchdog expired, the simulation hung");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0]         v;
        logic [sdram_aw-1:0] idx;
        int                  dl_len;
        data_errors  = 0;
        other_errors = 0;
        lfsr         = SEED;
        rst_n        = 1'b0;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_data   = '0;
        ioctl_wr     = 1'b0;
        {rom_cs, ram_cs, gfx_cs, snd_cs} = 4'b0000;
        rom_addr     = '0;
        ram_addr     = '0;
        gfx_addr     = '0;
        snd_addr     = '0;
        ram_we       = 1'b0;
        ram_din      = '0;
        ram_wrmask   = '0;
        for (int i = 0; i < (1 << sdram_aw); i++) begin
            idx       = sdram_aw'(i);
            shadow[i] = {idx[7:0], idx[15:8]} ^ {idx[21:16], idx[21:12]};
        end
        repeat (2) @(posedge VB);
        @(negedge VB);
        rst_n = 1'b1;
        repeat (4) @(negedge VB);

        // Download, bytes packed low then high
        get_bits(7, v);
        // Odd length leaves a lone even byte at the end
        dl_len = (16 + int'(v)) | 1;
        downloading = 1'b1;
        for (int b = 0; b < dl_len; b++) begin
            get_bits(8, v);
            ioctl_addr = (sdram_aw + 1)'(b);
            ioctl_data = v[7:0];
            ioctl_wr   = 1'b1;
            if (b % 2 == 0) shadow[b / 2][7:0] = v[7:0];
            else shadow[b / 2][15:8] = v[7:0];
            @(negedge VB);
            ioctl_wr = 1'b0;
            repeat (15) @(negedge VB);
        end
        downloading = 1'b0;
        repeat (32) @(negedge VB);
        for (int w = 0; w <= dl_len / 2; w++) begin
            if (u_mem.mem[w] !== shadow[w]) report_value("download word", u_mem.mem[w], shadow[w]);
        end

        for (int i = 0; i < N_READS; i++) begin
            pick_addr(0);
            run_access(4'b0001, 0);
            pick_addr(2);
            run_access(4'b0100, 0);
            pick_addr(3);
            run_access(4'b1000, 0);
        end

        // RAM writes, each read back
        for (int i = 0; i < N_WRITES; i++) begin
            pick_addr(1);
            get_bits(16, v);
            ram_din = v[15:0];
            get_bits(2, v);
            ram_wrmask = v[1:0];
            ram_we = 1'b1;
            run_access(4'b0010, 0);
            idx = ram_offset + ram_addr;
            if (ram_wrmask[0]) shadow[idx][7:0] = ram_din[7:0];
            if (ram_wrmask[1]) shadow[idx][15:8] = ram_din[15:8];
            ram_we = 1'b0;
            run_access(4'b0010, 0);
        end

        // All clients at once, held back by downloading first
        for (int i = 0; i < N_MULTI; i++) begin
            for (int c = 0; c < 4; c++) pick_addr(c);
            get_bits(3, v);
            run_access(4'b1111, 2 + int'(v[2:0]));
        end

        repeat (48) @(negedge VB);
        $display("Errors: %0d wrong values, %0d other failures", data_errors, other_errors);
        if (data_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: bench/wb_sdram_model.sv
`timescale 1ns/10ps

module wb_sdram_model (
    input  logic                   VB,
    input  logic                   rst_n,
    input  sdram_bus_pkg::wb_req_t wb,
    output sdram_bus_pkg::wb_rsp_t rsp
);

    import sdram_map_pkg::*;
    import sdram_bus_pkg::*;

    localparam logic [31:0] WAIT_SEED = 32'h1d87_4c35;

    logic [15:0] mem [0:(1 << sdram_aw) - 1];
    logic [31:0] lfsr;
    logic        busy;
    logic [2:0]  wait_cnt;

    // Power-up contents, a function of the whole word address
    function automatic logic [15:0] fill_word(input logic [sdram_aw-1:0] a);
        return {a[7:0], a[15:8]} ^ {a[21:16], a[21:12]};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    initial begin
        for (int i = 0; i < (1 << sdram_aw); i++) begin
            mem[i] = fill_word(sdram_aw'(i));
        end
    end

    always @(posedge VB) begin : bus_proc
        logic [31:0] s;
        logic [2:0]  w;
        if (!rst_n) begin
            rsp.ack <= 1'b0;
            busy    <= 1'b0;
            lfsr    <= WAIT_SEED;
        end else begin
            rsp.ack <= 1'b0;
            if (wb.cyc && wb.stb && !rsp.ack) begin
                if (!busy) begin
                    // New cycle, draw 0 to 7 wait states
                    s = lfsr;
                    w = '0;
                    for (int i = 0; i < 3; i++) begin
                        s = lfsr_next(s);
                        w = {w[1:0], s[0]};
                    end
                    lfsr     <= s;
                    wait_cnt <= w;
                    busy     <= 1'b1;
                end else if (wait_cnt == 0) begin
                    busy    <= 1'b0;
                    rsp.ack <= 1'b1;
                    if (wb.we && wb.sel[0]) begin
                        mem[wb.adr][7:0] <= wb.dat[7:0];
                    end
                    if (wb.we && wb.sel[1]) begin
                        mem[wb.adr][15:8] <= wb.dat[15:8];
                    end
                    rsp.dat <= {mem[sdram_aw'(wb.adr + 1'b1)], mem[wb.adr]};
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

endmodule

// File: src/cps_mem_top.sv
`timescale 1ns/10ps

module cps_mem_top #(
    parameter int PXL_N = 1,
    parameter int PXL_M = 6,
    parameter int CPU_N = 5,
    parameter int CPU_M = 24
) (
    input  logic                               VB,
    input  logic                               rst_n,
    // ROM download
    input  logic                               downloading,
    input  logic [sdram_map_pkg::sdram_aw:0]   ioctl_addr,
    input  logic [7:0]                         ioctl_data,
    input  logic                               ioctl_wr,
    // Main CPU ROM
    input  logic                               rom_cs,
    input  logic [sdram_map_pkg::rom_aw-1:0]   rom_addr,
    output logic                               rom_ok,
    output logic [15:0]                        rom_data,
    // Main CPU work RAM
    input  logic                               ram_cs,
    input  logic [sdram_map_pkg::ram_aw-1:0]   ram_addr,
    input  logic                               ram_we,
    input  logic [15:0]                        ram_din,
    input  logic [1:0]                         ram_wrmask,
    output logic                               ram_ok,
    output logic [15:0]                        ram_data,
    // Graphics ROM
    input  logic                               gfx_cs,
    input  logic [sdram_map_pkg::gfx_aw-1:0]   gfx_addr,
    output logic                               gfx_ok,
    output logic [31:0]                        gfx_data,
    // Sound ROM
    input  logic                               snd_cs,
    input  logic [sdram_map_pkg::snd_aw-1:0]   snd_addr,
    output logic                               snd_ok,
    output logic [7:0]                         snd_data,
    // SDRAM controller
    output sdram_bus_pkg::wb_req_t             sdram_wb,
    input  sdram_bus_pkg::wb_rsp_t             sdram_rsp,
    // Clock enables
    output logic                               pxl_cen,
    output logic                               cpu_cen
);

    import sdram_map_pkg::*;
    import sdram_bus_pkg::*;

    slot_req_t                dl_req;
    slot_req_t [n_slots-1:0]  slot_req;
    logic                     dl_ack;
    logic [n_slots-1:0]       slot_ack;
    logic [31:0]              rd_data;

    frac_cen #(.W(1), .N(PXL_N), .M(PXL_M)) u_pxl_cen (
        .VB    ( VB      ),
        .rst_n ( rst_n   ),
        .cen   ( pxl_cen )
    );

    frac_cen #(.W(1), .N(CPU_N), .M(CPU_M)) u_cpu_cen (
        .VB    ( VB      ),
        .rst_n ( rst_n   ),
        .cen   ( cpu_cen )
    );

    prom_writer u_prom (
        .VB          ( VB          ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .ack         ( dl_ack      ),
        .req         ( dl_req      )
    );

    slot_port #(.data_t(logic [15:0]), .AW(rom_aw), .OFFSET(rom_offset)) u_rom (
        .VB      ( VB          ),
        .rst_n   ( rst_n       ),
        .cs      ( rom_cs      ),
        .addr    ( rom_addr    ),
        .we      ( 1'b0        ),
        .din     ( 16'h0000    ),
        .wrmask  ( 2'b00       ),
        .ack     ( slot_ack[0] ),
        .rd_data ( rd_data     ),
        .req     ( slot_req[0] ),
        .data    ( rom_data    ),
        .ok      ( rom_ok      )
    );

    slot_port #(.data_t(logic [15:0]), .AW(ram_aw), .OFFSET(ram_offset),
                .WRITABLE(1'b1)) u_ram (
        .VB      ( VB          ),
        .rst_n   ( rst_n       ),
        .cs      ( ram_cs      ),
        .addr    ( ram_addr    ),
        .we      ( ram_we      ),
        .din     ( ram_din     ),
        .wrmask  ( ram_wrmask  ),
        .ack     ( slot_ack[1] ),
        .rd_data ( rd_data     ),
        .req     ( slot_req[1] ),
        .data    ( ram_data    ),
        .ok      ( ram_ok      )
    );

    slot_port #(.data_t(logic [31:0]), .AW(gfx_aw), .OFFSET(gfx_offset)) u_gfx (
        .VB      ( VB          ),
        .rst_n   ( rst_n       ),
        .cs      ( gfx_cs      ),
        .addr    ( gfx_addr    ),
        .we      ( 1'b0        ),
        .din     ( 16'h0000    ),
        .wrmask  ( 2'b00       ),
        .ack     ( slot_ack[2] ),
        .rd_data ( rd_data     ),
        .req     ( slot_req[2] ),
        .data    ( gfx_data    ),
        .ok      ( gfx_ok      )
    );

    slot_port #(.data_t(logic [7:0]), .AW(snd_aw), .OFFSET(snd_offset),
                .BYTE_LANE(1'b1)) u_snd (
        .VB      ( VB          ),
        .rst_n   ( rst_n       ),
        .cs      ( snd_cs      ),
        .addr    ( snd_addr    ),
        .we      ( 1'b0        ),
        .din     ( 16'h0000    ),
        .wrmask  ( 2'b00       ),
        .ack     ( slot_ack[3] ),
        .rd_data ( rd_data     ),
        .req     ( slot_req[3] ),
        .data    ( snd_data    ),
        .ok      ( snd_ok      )
    );

    slot_arbiter u_arb (
        .VB          ( VB          ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .dl_req      ( dl_req      ),
        .slot_req    ( slot_req    ),
        .sdram_rsp   ( sdram_rsp   ),
        .dl_ack      ( dl_ack      ),
        .slot_ack    ( slot_ack    ),
        .rd_data     ( rd_data     ),
        .sdram_wb    ( sdram_wb    )
    );

endmodule

// File: src/slot_arbiter.sv
`timescale 1ns/10ps

module slot_arbiter (
    input  logic                                                 VB,
    input  logic                                                 rst_n,
    input  logic                                                 downloading,
    input  sdram_bus_pkg::slot_req_t                             dl_req,
    input  sdram_bus_pkg::slot_req_t [sdram_map_pkg::n_slots-1:0] slot_req,
    input  sdram_bus_pkg::wb_rsp_t                               sdram_rsp,
    output logic                                                 dl_ack,
    output logic [sdram_map_pkg::n_slots-1:0]                    slot_ack,
    output logic [31:0]                                          rd_data,
    output sdram_bus_pkg::wb_req_t                               sdram_wb
);

    import sdram_map_pkg::*;
    import sdram_bus_pkg::*;

    localparam int IW = (n_slots > 1) ? $clog2(n_slots) : 1;

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t             state;
    logic               gnt_dl;
    logic [IW-1:0]      gnt_idx;
    logic [IW-1:0]      pick_idx;
    logic [n_slots-1:0] pending;
    logic               dl_pending;
    logic               any_pending;
    slot_req_t          next_req;

    // A requester whose ack is out this clock still shows req high
    always_comb begin
        dl_pending = dl_req.req && !dl_ack;
        for (int i = 0; i < n_slots; i++) begin
            pending[i] = slot_req[i].req && !slot_ack[i] && !downloading;
        end
        any_pending = |pending;
        // Lowest-numbered slot wins
        pick_idx = '0;
        for (int i = n_slots - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick_idx = IW'(i);
            end
        end
        next_req = dl_pending ? dl_req : slot_req[pick_idx];
    end

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            state    <= IDLE;
            sdram_wb <= '0;
            gnt_dl   <= 1'b0;
            gnt_idx  <= '0;
            dl_ack   <= 1'b0;
            slot_ack <= '0;
        end else begin
            dl_ack   <= 1'b0;
            slot_ack <= '0;
            case (state)
                IDLE: begin
                    if (dl_pending || any_pending) begin
                        sdram_wb <= '{cyc: 1'b1, stb: 1'b1, we: next_req.we,
                                      adr: next_req.adr, dat: next_req.dat,
                                      sel: next_req.sel};
                        gnt_dl   <= dl_pending;
                        gnt_idx  <= pick_idx;
                        state    <= BUSY;
                    end
                end
                BUSY: begin
                    // Cycle ends on ack, idle for at least one clock
                    if (sdram_rsp.ack) begin
                        sdram_wb.cyc <= 1'b0;
                        sdram_wb.stb <= 1'b0;
                        if (gnt_dl) begin
                            dl_ack <= 1'b1;
                        end else begin
                            slot_ack[gnt_idx] <= 1'b1;
                        end
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge VB) begin
        if (state == BUSY && sdram_rsp.ack) begin
            rd_data <= sdram_rsp.dat;
        end
    end

endmodule

// File: src/slot_port.sv
`timescale 1ns/10ps

module slot_port #(
    parameter type                                data_t    = logic [15:0],
    parameter int                                 AW        = 16,
    parameter logic [sdram_map_pkg::sdram_aw-1:0] OFFSET    = '0,
    parameter bit                                 BYTE_LANE = 1'b0,
    parameter bit                                 WRITABLE  = 1'b0
) (
    input  logic                     VB,
    input  logic                     rst_n,
    input  logic                     cs,
    input  logic [AW-1:0]            addr,
    input  logic                     we,
    input  logic [15:0]              din,
    input  logic [1:0]               wrmask,
    input  logic                     ack,
    input  logic [31:0]              rd_data,
    output sdram_bus_pkg::slot_req_t req,
    output data_t                    data,
    output logic                     ok
);

    import sdram_map_pkg::*;

    localparam int DW = $bits(data_t);

    logic [sdram_aw-1:0] word_adr;
    logic                wr_en;
    // Address and direction of the access, bit 1 is the byte lane
    logic [AW:0]         key;
    logic [AW:0]         last_key;
    logic                last_vld;
    logic                match;
    logic                busy;

    assign wr_en = WRITABLE && we;
    assign key   = {addr, wr_en};
    assign match = (key == last_key);

    always_comb begin
        if (BYTE_LANE) begin
            word_adr = OFFSET + sdram_aw'(addr >> 1);
        end else if (DW == 32) begin
            word_adr = OFFSET + sdram_aw'({addr, 1'b0});
        end else begin
            word_adr = OFFSET + sdram_aw'(addr);
        end
    end

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            req      <= '0;
            ok       <= 1'b0;
            busy     <= 1'b0;
            last_vld <= 1'b0;
            last_key <= '0;
        end else begin
            if (!cs || !match) begin
                ok <= 1'b0;
            end
            if (busy) begin
                if (ack) begin
                    req.req  <= 1'b0;
                    busy     <= 1'b0;
                    last_vld <= 1'b1;
                    // Stale data if the client moved on meanwhile
                    ok       <= cs && match;
                end
            end else if (cs && !(last_vld && match)) begin
                req.req  <= 1'b1;
                req.we   <= wr_en;
                req.adr  <= word_adr;
                req.dat  <= WRITABLE ? din : 16'h0000;
                req.sel  <= wr_en ? wrmask : 2'b11;
                busy     <= 1'b1;
                last_vld <= 1'b0;
                last_key <= key;
            end else if (!cs) begin
                // Next cs starts a fresh access
                last_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge VB) begin
        if (ack) begin
            if (BYTE_LANE) begin
                data <= data_t'(last_key[1] ? rd_data[15:8] : rd_data[7:0]);
            end else begin
                data <= data_t'(rd_data[DW-1:0]);
            end
        end
    end

endmodule

// File: src/prom_writer.sv
`timescale 1ns/10ps

module prom_writer (
    input  logic                                VB,
    input  logic                                rst_n,
    input  logic                                downloading,
    input  logic [sdram_map_pkg::sdram_aw:0]    ioctl_addr,
    input  logic [7:0]                          ioctl_data,
    input  logic                                ioctl_wr,
    input  logic                                ack,
    output sdram_bus_pkg::slot_req_t            req
);

    import sdram_map_pkg::*;
    import sdram_bus_pkg::*;

    logic                hold_vld;
    logic [sdram_aw-1:0] hold_adr;
    logic [7:0]          hold_dat;
    // Odd byte waiting behind a flush of the held even byte
    logic                odd_vld;
    logic [sdram_aw-1:0] odd_adr;
    logic [7:0]          odd_dat;
    logic                dl_l;
    logic [sdram_aw-1:0] strobe_adr;

    function automatic slot_req_t word_write(input logic [sdram_aw-1:0] adr,
                                             input logic [15:0] dat,
                                             input logic [1:0] sel);
        slot_req_t r;
        r.req = 1'b1;
        r.we  = 1'b1;
        r.adr = adr;
        r.dat = dat;
        r.sel = sel;
        return r;
    endfunction

    assign strobe_adr = ioctl_addr[sdram_aw:1];

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            req      <= '0;
            hold_vld <= 1'b0;
            odd_vld  <= 1'b0;
            dl_l     <= 1'b0;
        end else begin
            dl_l <= downloading;
            if (ack) begin
                req.req <= 1'b0;
                if (odd_vld) begin
                    req     <= word_write(odd_adr, {odd_dat, 8'h00}, 2'b10);
                    odd_vld <= 1'b0;
                end
            end
            if (ioctl_wr && downloading) begin
                if (!ioctl_addr[0]) begin
                    // New even byte, a previous lone one goes out first
                    if (hold_vld) begin
                        req <= word_write(hold_adr, {8'h00, hold_dat}, 2'b01);
                    end
                    hold_vld <= 1'b1;
                    hold_adr <= strobe_adr;
                    hold_dat <= ioctl_data;
                end else if (hold_vld && hold_adr == strobe_adr) begin
                    req      <= word_write(hold_adr, {ioctl_data, hold_dat}, 2'b11);
                    hold_vld <= 1'b0;
                end else if (hold_vld) begin
                    req      <= word_write(hold_adr, {8'h00, hold_dat}, 2'b01);
                    hold_vld <= 1'b0;
                    odd_vld  <= 1'b1;
                    odd_adr  <= strobe_adr;
                    odd_dat  <= ioctl_data;
                end else begin
                    req <= word_write(strobe_adr, {ioctl_data, 8'h00}, 2'b10);
                end
            end else if (dl_l && !downloading && hold_vld) begin
                // Trailing even byte at the end of the download
                req      <= word_write(hold_adr, {8'h00, hold_dat}, 2'b01);
                hold_vld <= 1'b0;
            end
        end
    end

endmodule

// File: src/frac_cen.sv
`timescale 1ns/10ps

module frac_cen #(
    parameter int W = 1,
    parameter int N = 1,
    parameter int M = 6
) (
    input  logic         VB,
    input  logic         rst_n,
    output logic [W-1:0] cen
);

    // Wide enough to hold acc + N before the wrap
    localparam int CW = $clog2(M + N) + 1;

    logic [CW-1:0] acc;
    logic [CW-1:0] acc_next;
    // Wrap count for the divided enables
    logic [W-1:0]  wraps;

    assign acc_next = acc + CW'(N);

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            acc   <= '0;
            wraps <= '0;
            cen   <= '0;
        end else begin
            cen <= '0;
            if (acc_next >= CW'(M)) begin
                acc    <= acc_next - CW'(M);
                wraps  <= wraps + 1'b1;
                cen[0] <= 1'b1;
                // cen[i] on every 2^i-th wrap
                for (int i = 1; i < W; i++) begin
                    if ((wraps & W'((1 << i) - 1)) == W'((1 << i) - 1)) begin
                        cen[i] <= 1'b1;
                    end
                end
            end else begin
                acc <= acc_next;
            end
        end
    end

endmodule

// File: src/sdram_bus_pkg.sv
package sdram_bus_pkg;

    // Wishbone classic master outputs toward the SDRAM controller
    typedef struct packed {
        logic                               cyc;
        logic                               stb;
        logic                               we;
        // Word address
        logic [sdram_map_pkg::sdram_aw-1:0] adr;
        logic [15:0]                        dat;
        // Byte lanes, bit 0 is the low byte
        logic [1:0]                         sel;
    } wb_req_t;

    // Slave response
    typedef struct packed {
        logic        ack;
        // Word at adr in the low half, word at adr+1 in the high half
        logic [31:0] dat;
    } wb_rsp_t;

    // Request from a slot port or the download writer to the arbiter
    typedef struct packed {
        logic                               req;
        logic                               we;
        // Absolute SDRAM word address
        logic [sdram_map_pkg::sdram_aw-1:0] adr;
        logic [15:0]                        dat;
        logic [1:0]                         sel;
    } slot_req_t;

endpackage

// File: src/sdram_map_pkg.sv
package sdram_map_pkg;

    // SDRAM word address width, 4M x 16
    localparam int sdram_aw = 22;

    // Base word address of each region
    localparam logic [sdram_aw-1:0] rom_offset = 22'h00_0000;
    localparam logic [sdram_aw-1:0] ram_offset = 22'h3A_8000;
    localparam logic [sdram_aw-1:0] gfx_offset = 22'h0A_8000;
    localparam logic [sdram_aw-1:0] snd_offset = 22'h08_0000;

    // Main CPU ROM, word address
    localparam int rom_aw = 19;

    // Main CPU work RAM, word address
    localparam int ram_aw = 17;

    // Graphics ROM, one address per 32-bit item
    localparam int gfx_aw = 20;

    // Sound CPU ROM, byte address
    localparam int snd_aw = 16;

    // Client slots behind the arbiter
    // 0 rom, 1 ram, 2 gfx, 3 snd
    localparam int n_slots = 4;

endpackage
